/* cpu_ctrl_pkg.sv */
/*
    cpu control package
    opcode groups, condition code bit positions, the stacked register
    order and the byte and word types shared by the control blocks
*/
`default_nettype none

package cpu_ctrl_pkg;

    typedef logic [15:0] addr_t;     // pc or operand word
    typedef logic [ 7:0] byte_t;     // opcode, postbyte or cc
    typedef logic [ 2:0] reg_sel_t;  // stacked register, equals the postbyte bit

    // opcode groups
    localparam byte_t op_bra_base = 8'h20;  // 2x, low nibble picks the condition
    localparam byte_t op_lbra     = 8'h16;  // long branch always, absolute here
    localparam byte_t op_jmp      = 8'h7E;  // extended jump
    localparam byte_t op_pshs     = 8'h34;
    localparam byte_t op_puls     = 8'h35;
    localparam byte_t op_pshu     = 8'h36;
    localparam byte_t op_pulu     = 8'h37;

    // bit positions inside cc
    localparam int cc_c = 0;  // carry
    localparam int cc_v = 1;  // overflow
    localparam int cc_z = 2;  // zero
    localparam int cc_n = 3;  // negative

    // branch condition codes, low nibble of a short branch
    localparam logic [3:0] cond_ra = 4'h0;  // always
    localparam logic [3:0] cond_rn = 4'h1;  // never
    localparam logic [3:0] cond_hi = 4'h2;
    localparam logic [3:0] cond_ls = 4'h3;
    localparam logic [3:0] cond_cc = 4'h4;  // also bhs
    localparam logic [3:0] cond_cs = 4'h5;  // also blo
    localparam logic [3:0] cond_ne = 4'h6;
    localparam logic [3:0] cond_eq = 4'h7;
    localparam logic [3:0] cond_vc = 4'h8;
    localparam logic [3:0] cond_vs = 4'h9;
    localparam logic [3:0] cond_pl = 4'hA;
    localparam logic [3:0] cond_mi = 4'hB;
    localparam logic [3:0] cond_ge = 4'hC;  // signed compares from here on
    localparam logic [3:0] cond_lt = 4'hD;
    localparam logic [3:0] cond_gt = 4'hE;
    localparam logic [3:0] cond_le = 4'hF;

    // stacking order
    // push walks 7 down to 0, pull walks 0 up to 7
    localparam reg_sel_t reg_pc = 3'd7;
    localparam reg_sel_t reg_us = 3'd6;  // U on the S stack, S on the U stack
    localparam reg_sel_t reg_y  = 3'd5;
    localparam reg_sel_t reg_x  = 3'd4;
    localparam reg_sel_t reg_dp = 3'd3;
    localparam reg_sel_t reg_b  = 3'd2;
    localparam reg_sel_t reg_a  = 3'd1;
    localparam reg_sel_t reg_cc = 3'd0;

    // postbyte bits whose register takes two bytes on the stack
    localparam byte_t wide_regs = 8'hF0;

endpackage

`default_nettype wire

/* branch_cond.sv */
/*
    branch condition evaluator
    decodes the sixteen 6809 short branch conditions from the opcode low
    nibble and the C, V, Z and N flags, purely combinational
*/
`default_nettype none

module branch_cond (
    input  cpu_ctrl_pkg::byte_t op,
    input  cpu_ctrl_pkg::byte_t cc,
    output logic                taken
);
    import cpu_ctrl_pkg::*;

    logic c;
    logic v;
    logic z;
    logic n;
    logic nv;      // n xor v, signed less than
    logic cond;    // condition holds, opcode group not checked yet
    logic is_bra;  // 2x opcode

    assign c  = cc[cc_c];
    assign v  = cc[cc_v];
    assign z  = cc[cc_z];
    assign n  = cc[cc_n];
    assign nv = n ^ v;

    assign is_bra = (op[7:4] == op_bra_base[7:4]);

    always_comb begin
        case (op[3:0])
            cond_ra: cond = 1'b1;
            cond_rn: cond = 1'b0;
            cond_hi: cond = ~(c | z);      // unsigned higher
            cond_ls: cond = c | z;         // unsigned lower or same
            cond_cc: cond = ~c;
            cond_cs: cond = c;
            cond_ne: cond = ~z;
            cond_eq: cond = z;
            cond_vc: cond = ~v;
            cond_vs: cond = v;
            cond_pl: cond = ~n;
            cond_mi: cond = n;
            cond_ge: cond = ~nv;
            cond_lt: cond = nv;
            cond_gt: cond = ~(z | nv);     // signed greater
            cond_le: cond = z | nv;
            default: cond = 1'b0;
        endcase
    end

    // only a short branch can be taken, other opcodes just fall through
    assign taken = is_bra & cond;

endmodule

`default_nettype wire

/* stack_seq.sv */
/*
    push and pull sequencer
    latches the postbyte mask of a stack opcode and walks it one byte per
    enabled cycle, 16-bit registers take two steps
*/
`default_nettype none

module stack_seq (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   exec,
    input  cpu_ctrl_pkg::byte_t    op,
    input  cpu_ctrl_pkg::byte_t    postbyte,
    output logic                   busy,
    output logic                   stk_step,
    output logic                   stk_we,
    output logic                   pul_en,
    output logic                   hi_lon,
    output logic                   us_sel,
    output cpu_ctrl_pkg::reg_sel_t reg_sel
);
    import cpu_ctrl_pkg::*;

    byte_t    rem;         // mask bits not started yet
    logic     pull;        // latched direction, 1 for pull
    logic     op_pull;
    logic     op_us;
    logic     is_stk;      // one of the four push/pull opcodes
    logic     start;       // nonempty push or pull accepted
    logic     cur_wide;    // current register stacks two bytes
    logic     first_half;  // second byte of a wide register still due
    logic     last;        // current byte closes the sequence
    byte_t    pick_mask;
    logic     pick_up;     // search from bit 0 upwards
    reg_sel_t nxt_sel;

    // lowest set bit when up, highest otherwise
    function automatic reg_sel_t first_bit(input byte_t m, input logic up);
        reg_sel_t sel;
        sel = '0;
        if (up) begin
            for (int i = 7; i >= 0; i--) begin
                if (m[i]) begin
                    sel = reg_sel_t'(i);
                end
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (m[i]) begin
                    sel = reg_sel_t'(i);
                end
            end
        end
        return sel;
    endfunction

    assign op_pull = (op == op_puls) || (op == op_pulu);
    assign op_us   = (op == op_pshu) || (op == op_pulu);
    assign is_stk  = (op == op_pshs) || (op == op_pshu) || op_pull;

    // an empty mask is accepted as a plain opcode, busy stays low
    assign start = exec && !busy && is_stk && (postbyte != 8'h00);

    // search the new postbyte when idle and what is left when busy
    assign pick_mask = busy ? rem : postbyte;
    assign pick_up   = busy ? pull : op_pull;
    assign nxt_sel   = first_bit(pick_mask, pick_up);

    assign cur_wide   = wide_regs[reg_sel];
    assign first_half = cur_wide && (hi_lon == pull);  // push starts low, pull starts high
    assign last       = !first_half && (rem == 8'h00);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            pull    <= 1'b0;
            us_sel  <= 1'b0;
            hi_lon  <= 1'b0;
            reg_sel <= '0;
            rem     <= '0;
        end else if (cen) begin
            if (start) begin
                busy    <= 1'b1;
                pull    <= op_pull;
                us_sel  <= op_us;
                reg_sel <= nxt_sel;
                rem     <= postbyte & ~(8'h01 << nxt_sel);
                hi_lon  <= op_pull & wide_regs[nxt_sel];  // 8-bit regs keep hi_lon low
            end else if (busy) begin
                if (first_half) begin
                    hi_lon <= ~hi_lon;                    // same register, other half
                end else if (last) begin
                    busy   <= 1'b0;
                    hi_lon <= 1'b0;
                    us_sel <= 1'b0;                       // stack select only during steps
                end else begin
                    reg_sel <= nxt_sel;                   // move on to next mask bit
                    rem     <= rem & ~(8'h01 << nxt_sel);
                    hi_lon  <= pull & wide_regs[nxt_sel];
                end
            end
        end
    end

    // one step per byte, so the strobe spans exactly the busy window
    assign stk_step = busy;
    assign stk_we   = busy & ~pull;
    assign pul_en   = busy & pull;

endmodule

`default_nettype wire

/* pc_unit.sv */
/*
    program counter unit
    picks the next pc from interrupt vector, taken branch, absolute load
    or increment, and writes pulled bytes into pc during a pull
*/
`default_nettype none

module pc_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   exec,
    input  logic                   int_take,
    input  cpu_ctrl_pkg::byte_t    op,
    input  cpu_ctrl_pkg::addr_t    data,
    input  logic                   taken,
    input  logic                   busy,
    input  logic                   pul_en,
    input  logic                   stk_step,
    input  logic                   hi_lon,
    input  cpu_ctrl_pkg::reg_sel_t reg_sel,
    output cpu_ctrl_pkg::addr_t    pc
);
    import cpu_ctrl_pkg::*;

    addr_t pc_inc;   // address after the opcode
    addr_t rel;      // sign extended short offset
    addr_t nxt_pc;   // value taken on an accepted instruction
    logic  is_abs;   // long branch or jump
    logic  pul_pc;   // pull step that targets pc

    assign pc_inc = pc + 16'd1;
    assign rel    = {{8{data[7]}}, data[7:0]};
    assign is_abs = (op == op_lbra) || (op == op_jmp);
    assign pul_pc = stk_step && pul_en && (reg_sel == reg_pc);

    always_comb begin
        if (int_take) begin
            nxt_pc = data;             // vector wins over exec
        end else if (taken) begin
            nxt_pc = pc_inc + rel;     // offset counts from the next address
        end else if (is_abs) begin
            nxt_pc = data;
        end else begin
            nxt_pc = pc_inc;           // not taken, stack ops, anything else
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (cen) begin
            if (!busy) begin
                if (int_take || exec) begin
                    pc <= nxt_pc;
                end
            end else if (pul_pc) begin
                // pull sends the high byte first
                if (hi_lon) begin
                    pc[15:8] <= data[7:0];
                end else begin
                    pc[7:0] <= data[7:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* cpu_ctrl.sv */
/*
    cpu control top level
    ties the branch evaluator and the stack sequencer to the pc unit
*/
`default_nettype none

module cpu_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   exec,
    input  cpu_ctrl_pkg::byte_t    op,
    input  cpu_ctrl_pkg::byte_t    postbyte,
    input  cpu_ctrl_pkg::byte_t    cc,
    input  cpu_ctrl_pkg::addr_t    data,
    input  logic                   int_take,
    output cpu_ctrl_pkg::addr_t    pc,
    output logic                   busy,
    output logic                   stk_step,
    output logic                   stk_we,
    output logic                   pul_en,
    output logic                   hi_lon,
    output logic                   us_sel,
    output cpu_ctrl_pkg::reg_sel_t reg_sel
);

    logic taken;     // short branch condition met
    logic seq_exec;  // exec that is not overridden by an interrupt

    // int_take shadows exec, no stack sequence starts under it
    assign seq_exec = exec & ~int_take;

    branch_cond u_branch (
        .op       ( op       ),
        .cc       ( cc       ),
        .taken    ( taken    )
    );

    stack_seq u_stack (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( cen      ),
        .exec     ( seq_exec ),
        .op       ( op       ),
        .postbyte ( postbyte ),
        .busy     ( busy     ),
        .stk_step ( stk_step ),
        .stk_we   ( stk_we   ),
        .pul_en   ( pul_en   ),
        .hi_lon   ( hi_lon   ),
        .us_sel   ( us_sel   ),
        .reg_sel  ( reg_sel  )
    );

    pc_unit u_pc (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( cen      ),
        .exec     ( exec     ),
        .int_take ( int_take ),
        .op       ( op       ),
        .data     ( data     ),
        .taken    ( taken    ),
        .busy     ( busy     ),
        .pul_en   ( pul_en   ),
        .stk_step ( stk_step ),
        .hi_lon   ( hi_lon   ),
        .reg_sel  ( reg_sel  ),
        .pc       ( pc       )
    );

endmodule

`default_nettype wire

/* cpu_ctrl_tb.sv */
/*
    cpu control testbench
    replays the instruction patterns against the top level, keeps its own
    pc model and step list, and checks pc and every stack step
*/
`default_nettype none

module cpu_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_ctrl_pkg::*;

    localparam int kind_ex = 0;  // exec alone
    localparam int kind_it = 1;  // int_take alone
    localparam int kind_ix = 2;  // int_take and exec on the same cycle

    logic     clk;
    logic     rst;
    logic     cen;
    logic     exec;
    logic     int_take;
    byte_t    op;
    byte_t    postbyte;
    byte_t    cc;
    addr_t    data;
    addr_t    pc;
    logic     busy;
    logic     stk_step;
    logic     stk_we;
    logic     pul_en;
    logic     hi_lon;
    logic     us_sel;
    reg_sel_t reg_sel;

    int       pat_kind[$];   // one entry per pattern line
    byte_t    pat_op[$];
    byte_t    pat_pb[$];
    byte_t    pat_cc[$];
    addr_t    pat_data[$];
    addr_t    pat_exp[$];
    reg_sel_t exp_sel[$];    // expected steps of the running push or pull
    logic     exp_hl[$];

    int       seed = 32'h9019;
    int       pass_cnt = 0;
    int       fail_cnt = 0;
    int       test_err = 0;
    int       bad_lines = 0;
    addr_t    model_pc;
    bit       loaded = 1'b0;

    cpu_ctrl dut (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( cen      ),
        .exec     ( exec     ),
        .op       ( op       ),
        .postbyte ( postbyte ),
        .cc       ( cc       ),
        .data     ( data     ),
        .int_take ( int_take ),
        .pc       ( pc       ),
        .busy     ( busy     ),
        .stk_step ( stk_step ),
        .stk_we   ( stk_we   ),
        .pul_en   ( pul_en   ),
        .hi_lon   ( hi_lon   ),
        .us_sel   ( us_sel   ),
        .reg_sel  ( reg_sel  )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ends the run after 40 cycles per pattern plus slack for reset
    initial begin
        wait (loaded);
        #((pat_op.size() * 40 + 100) * 10);
        $display("timeout: the run did not finish in the time allowed for its patterns");
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic check_pc(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s pc is %h, expected %h", $time, what, got, exp);
            test_err++;
        end
    endtask

    // bits are busy, stk_step, stk_we, pul_en, hi_lon, us_sel
    task automatic check_step(input reg_sel_t got_sel, input reg_sel_t exp_sel_v,
                              input logic [5:0] got_bits, input logic [5:0] exp_bits,
                              input string what);
        if (got_sel !== exp_sel_v || got_bits !== exp_bits) begin
            $display("[ERROR] %0d ns: %s reg_sel %0d bits %b, expected reg_sel %0d bits %b",
                     $time, what, got_sel, got_bits, exp_sel_v, exp_bits);
            test_err++;
        end
    endtask

    // odd condition codes test the flag term directly, even ones its inverse
    function automatic logic cond_holds(input byte_t o, input byte_t f);
        logic nv;
        logic term;
        nv = f[cc_n] ^ f[cc_v];
        case (o[3:1])
            3'd0:    term = 1'b0;                 // brn and its inverse bra
            3'd1:    term = f[cc_c] | f[cc_z];    // bls / bhi
            3'd2:    term = f[cc_c];              // bcs / bcc
            3'd3:    term = f[cc_z];              // beq / bne
            3'd4:    term = f[cc_v];              // bvs / bvc
            3'd5:    term = f[cc_n];              // bmi / bpl
            3'd6:    term = nv;                   // blt / bge
            default: term = f[cc_z] | nv;         // ble / bgt
        endcase
        return o[0] ? term : ~term;
    endfunction

    function automatic addr_t next_pc(input int kind, input byte_t o, input byte_t f,
                                      input addr_t d, input addr_t cur);
        if (kind != kind_ex) begin
            return d;                             // a vector load also beats exec
        end
        if (o[7:4] == 4'h2 && cond_holds(o, f)) begin
            return cur + 16'd1 + {{8{d[7]}}, d[7:0]};
        end
        if (o == op_lbra || o == op_jmp) begin
            return d;
        end
        return cur + 16'd1;
    endfunction

    function automatic int kind_code(input logic [31:0] kw);
        if (kw == {16'd0, "ex"}) return kind_ex;
        if (kw == {16'd0, "it"}) return kind_it;
        if (kw == {16'd0, "ix"}) return kind_ix;
        return -1;
    endfunction

    // push walks bit 7 down with low byte first, pull walks bit 0 up with high first
    task automatic build_steps(input byte_t mask, input logic pull);
        reg_sel_t r;
        exp_sel.delete();
        exp_hl.delete();
        for (int k = 0; k < 8; k++) begin
            r = pull ? reg_sel_t'(k) : reg_sel_t'(7 - k);
            if (mask[r]) begin
                exp_sel.push_back(r);
                if (wide_regs[r]) begin
                    exp_hl.push_back(pull);
                    exp_sel.push_back(r);
                    exp_hl.push_back(~pull);
                end else begin
                    exp_hl.push_back(1'b0);
                end
            end
        end
    endtask

    task automatic load_patterns();
        int              fd;
        int              n;
        logic [31:0]     kw;
        logic [8*96-1:0] rest;
        byte_t           f_op;
        byte_t           f_pb;
        byte_t           f_cc;
        addr_t           f_data;
        addr_t           f_exp;
        fd = $fopen("cpu_ctrl_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open cpu_ctrl_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                kw = '0;
                n  = $fscanf(fd, "%s", kw);
                if (n == 1 && kw == {24'd0, "#"}) begin
                    n = $fgets(rest, fd);         // rest of a comment line
                end else if (n == 1) begin
                    n = $fscanf(fd, "%h %h %h %h %h", f_op, f_pb, f_cc, f_data, f_exp);
                    if (n != 5 || kind_code(kw) < 0) begin
                        $display("unreadable pattern line starting with %s", kw);
                        bad_lines++;
                    end else begin
                        pat_kind.push_back(kind_code(kw));
                        pat_op.push_back(f_op);
                        pat_pb.push_back(f_pb);
                        pat_cc.push_back(f_cc);
                        pat_data.push_back(f_data);
                        pat_exp.push_back(f_exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_test(input int num, input string desc);
        if (test_err == 0) begin
            pass_cnt++;
            $display("test %0d %s: ok", num, desc);
        end else begin
            fail_cnt++;
            $display("test %0d %s: failed with %0d errors", num, desc, test_err);
        end
    endtask

    task automatic run_test(input int idx);
        int    kind;
        int    rnd;
        int    pos;
        int    guard;
        logic  is_stk;
        logic  pull;
        byte_t o;
        addr_t d;
        kind     = pat_kind[idx];
        o        = pat_op[idx];
        d        = pat_data[idx];
        test_err = 0;
        is_stk   = (kind == kind_ex) && (o >= op_pshs) && (o <= op_pulu);
        pull     = o[0];                              // 35 and 37 pull
        exp_sel.delete();
        exp_hl.delete();
        if (is_stk) build_steps(pat_pb[idx], pull);
        rnd = $random(seed);
        repeat (rnd & 3) begin                        // zero to three idle cycles
            @(negedge clk);
            exec     = 1'b0;
            int_take = 1'b0;
        end
        @(negedge clk);
        exec     = (kind != kind_it);
        int_take = (kind != kind_ex);
        op       = o;
        postbyte = pat_pb[idx];
        cc       = pat_cc[idx];
        data     = d;
        @(negedge clk);                               // accepted on the edge just passed
        exec     = 1'b0;
        int_take = 1'b0;
        model_pc = next_pc(kind, o, pat_cc[idx], d, model_pc);
        pos   = 0;
        guard = 0;
        while (busy && pos < exp_sel.size() && guard < 40) begin
            check_step(reg_sel, exp_sel[pos], {busy, stk_step, stk_we, pul_en, hi_lon, us_sel},
                       {2'b11, ~pull, pull, exp_hl[pos], o[1]}, "step");
            rnd  = $random(seed);
            exec = rnd[0];                            // must be ignored while busy
            op   = op_jmp;
            if (pull) begin
                data = exp_hl[pos] ? {8'h00, d[15:8]} : {8'h00, d[7:0]};
            end else begin
                data = 16'hDEAD;                      // a slipped jump would show in pc
            end
            cen = cen ? (rnd[3:2] != 2'b00) : 1'b1;   // never low twice in a row
            if (cen) pos++;
            @(negedge clk);
            guard++;
        end
        exec = 1'b0;
        cen  = 1'b1;
        if (pos < exp_sel.size()) begin
            $display("%0d ns: test %0d missed stack steps, saw %0d of %0d",
                     $time, idx + 1, pos, exp_sel.size());
            test_err++;
        end else if (busy) begin
            $display("%0d ns: test %0d has busy stuck high after its last step",
                     $time, idx + 1);
            test_err++;
        end
        if (is_stk && pull && pat_pb[idx][7]) begin
            model_pc = d;                             // pulled high byte then low byte
        end
        check_step(reg_sel, reg_sel, {busy, stk_step, stk_we, pul_en, hi_lon, us_sel},
                   6'b000000, "idle");
        check_pc(pc, model_pc, "after instruction");
        if (model_pc !== pat_exp[idx]) begin
            $display("test %0d pattern expects pc %h but the pc rules give %h",
                     idx + 1, pat_exp[idx], model_pc);
            test_err++;
        end
        report_test(idx + 1, $sformatf("op %h pb %h cc %h pc %h", o, pat_pb[idx],
                                       pat_cc[idx], pc));
    endtask

    initial begin
        rst      = 1'b1;
        cen      = 1'b1;
        exec     = 1'b0;
        int_take = 1'b0;
        op       = '0;
        postbyte = '0;
        cc       = '0;
        data     = '0;
        model_pc = '0;
        load_patterns();
        if (pat_op.size() == 0) begin
            $display("no usable pattern lines were read");
            fail_cnt++;
        end
        fail_cnt += bad_lines;
        loaded = 1'b1;
        repeat (4) @(negedge clk);                    // four cycles in reset
        rst = 1'b0;
        @(negedge clk);
        test_err = 0;
        check_pc(pc, 16'h0000, "reset");
        check_step(reg_sel, reg_sel, {busy, stk_step, stk_we, pul_en, hi_lon, us_sel},
                   6'b000000, "reset");
        report_test(0, "reset values");
        for (int i = 0; i < pat_op.size(); i++) begin
            run_test(i);
        end
        $display("passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpu_ctrl_patterns.txt */
# columns: kind op postbyte cc data expected_pc, all but kind in hex
# kind ex is exec alone, it is int_take alone, ix is int_take with exec
ex 12 00 00 0000 0001
ex 12 00 00 0000 0002
ex 4F 00 00 0000 0003
ex 20 00 00 0010 0014
ex 21 00 00 0010 0015
ex 22 00 00 0020 0036
ex 22 00 01 0020 0037
ex 23 00 04 00F0 0028
ex 23 00 00 00F0 0029
ex 24 00 00 0005 002F
ex 25 00 00 0005 0030
ex 25 00 01 00FE 002F
ex 26 00 00 0040 0070
ex 27 00 00 0040 0071
ex 27 00 04 0090 0002
ex 28 00 00 007F 0082
ex 29 00 00 007F 0083
ex 29 00 02 00C0 0044
ex 2A 00 00 0003 0048
ex 2B 00 08 00FC 0045
ex 2C 00 0A 0010 0056
ex 2D 00 08 00F8 004F
ex 2E 00 00 0011 0061
ex 2E 00 04 0011 0062
ex 2F 00 04 00E0 0043
ex 2F 00 00 00E0 0044
ex 2C 00 08 0010 0045
ex 16 00 00 1234 1234
ex 7E 00 04 2000 2000
it 12 00 00 FFF8 FFF8
ix 20 00 00 3000 3000
ix 34 FF 00 3100 3100
ex 34 FF 00 0000 3101
ex 36 C5 00 0000 3102
ex 34 00 00 0000 3103
ex 35 16 00 0000 3104
ex 37 00 00 0000 3105
ex 35 81 00 4567 4567
ex 37 F0 00 89AB 89AB
ex 12 00 00 0000 89AC
ex 36 0E 00 0000 89AD
ex 22 00 05 0010 89AE
ex 2A 00 08 0010 89AF
ex 2B 00 00 0010 89B0

/* cpu_ctrl.f */
cpu_ctrl_pkg.sv
branch_cond.sv
stack_seq.sv
pc_unit.sv
cpu_ctrl.sv
cpu_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cpu control testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f cpu_ctrl.f \
    --top-module cpu_ctrl_tb -o cpu_ctrl_sim
./obj_dir/cpu_ctrl_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
